/* flist.f */
+incdir+.
cam_pixel_pkg.sv
cam_dma_pkg.sv
cam_frame_packer.sv
cam_dma_fifo.sv
cam_dma_writer.sv
cam_capture_top.sv
tb_cam_capture.sv

/* Bender.yml */
package:
  name: cam_capture

sources:
  - include_dirs:
      - .
    files:
      - cam_pixel_pkg.sv
      - cam_dma_pkg.sv
      - cam_frame_packer.sv
      - cam_dma_fifo.sv
      - cam_dma_writer.sv
      - cam_capture_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cam_capture.sv

/* tb_cam_capture.sv */
//////////////////////////////////////////////////
// Testbench for the capture back end
// Frames are 4 lines of 8 pairs after one vsync pulse
// DMA beats are checked in order against a model queue
// The overflow test leaves continuous capture on
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cam_defines.svh"

module tb_cam_capture;

   import cam_pixel_pkg::*;
   import cam_dma_pkg::*;

   localparam int BURST = `CAM_DMA_BURST_LEN;
   localparam int LIMIT = 2000;

   logic        mipi_pclk;
   logic        rst_n;
   cam_in_t     cam;
   logic        trigger;
   logic        continuous;
   logic        rgb_gray;
   logic        init_done;
   logic        wready;
   logic        wvalid;
   logic        wlast;
   dma_beat_t   wdata;
   logic        frame_start;
   logic        overflow;
   logic [31:0] dma_status;
   logic [31:0] wcount;
   logic [31:0] rcount;

   integer      seed = 32'h7dce_79a4;
   logic [31:0] rnd_word;
   logic [63:0] exp_q[$];
   logic [63:0] exp_beat;
   string       test_name;
   bit          rand_ready;
   logic        ready_level;
   int          push_left;
   int          init_count;
   int          beat_count;
   int          vs_falls;
   int          frame_starts;
   int          checks;
   int          mismatches;
   int          failures;

   cam_capture_top DUT (
      .i_mipi_pclk          (mipi_pclk),
      .i_rst_n              (rst_n),
      .i_cam                (cam),
      .i_trigger_capture    (trigger),
      .i_continuous_capture (continuous),
      .i_rgb_gray           (rgb_gray),
      .i_dma_init_done      (init_done),
      .i_dma_wready         (wready),
      .o_dma_wvalid         (wvalid),
      .o_dma_wlast          (wlast),
      .o_dma_wdata          (wdata),
      .o_frame_start        (frame_start),
      .o_fifo_overflow      (overflow),
      .o_dma_status         (dma_status),
      .o_dbg_wcount         (wcount),
      .o_dbg_rcount         (rcount)
   );

   // Expected DMA beat from one input pair
   // Each pixel is b, g, r from the top under a zero pad byte
   function automatic logic [63:0] ref_beat(logic [47:0] pair, bit gray);
      logic [23:0] px [2];
      int          y;
      px[0] = pair[23:0];
      px[1] = pair[47:24];
      for (int i = 0; i < 2; i++) begin
         if (gray) begin
            y     = (77 * px[i][7:0] + 150 * px[i][15:8] + 29 * px[i][23:16]) >> 8;
            px[i] = {3{y[7:0]}};
         end
      end
      return {8'h00, px[1], 8'h00, px[0]};
   endfunction

   initial begin
      mipi_pclk = 1'b0;
      forever #10 mipi_pclk = ~mipi_pclk;
   end

   // Sink readiness is random or held
   always @(negedge mipi_pclk) begin
      if (rand_ready) begin
         rnd_word = $random(seed);
         wready <= rnd_word[0];
      end else begin
         wready <= ready_level;
      end
   end

   // Frame start pulses seen on the DUT output
   always @(posedge mipi_pclk) begin
      if (rst_n && frame_start) begin
         frame_starts++;
      end
   end

   //////////////////////////////////////////////////
   // Beat checker
   //////////////////////////////////////////////////

   always @(posedge mipi_pclk) begin
      if (rst_n && wvalid) begin
         beat_count++;
         assert (beat_count <= BURST * init_count) else begin
            failures++;
            $display("ERROR: %s beat %0d went out without an init_done edge",
                     test_name, beat_count);
         end
         assert (wlast == (beat_count % BURST == 0)) else begin
            mismatches++;
            $display("MISMATCH %s wlast at beat %0d: expected %0b actual %0b", test_name,
                     beat_count, (beat_count % BURST == 0), wlast);
         end
         assert (exp_q.size() > 0) else begin
            failures++;
            $display("ERROR: %s beat %0d came with no captured word left", test_name, beat_count);
         end
         if (exp_q.size() > 0) begin
            exp_beat = exp_q.pop_front();
            checks++;
            assert (wdata == exp_beat) else begin
               mismatches++;
               $display("MISMATCH %s beat %0d: expected %h actual %h", test_name, beat_count,
                        exp_beat, wdata);
            end
         end
      end
   end

   task automatic wait_beats(input int target);
      int cyc;
      cyc = 0;
      while (beat_count < target && cyc < LIMIT) begin
         @(negedge mipi_pclk);
         cyc++;
      end
      assert (beat_count >= target) else begin
         failures++;
         $display("ERROR: %s timed out after %0d cycles waiting for beat %0d",
                  test_name, LIMIT, target);
      end
   endtask

   // One init_done pulse per burst
   // The next pulse waits for the burst to finish
   task automatic run_bursts(input int n);
      repeat (n) begin
         @(negedge mipi_pclk);
         init_done = 1'b1;
         init_count++;
         repeat (2) @(negedge mipi_pclk);
         init_done = 1'b0;
         wait_beats(BURST * init_count);
      end
   endtask

   task automatic check_idle();
      logic [31:0] exp_status;
      repeat (20) @(negedge mipi_pclk);
      exp_status = {29'd0, 1'b1, 1'b0, wready};
      assert (exp_q.size() == 0) else begin
         failures++;
         $display("ERROR: %s left %0d captured words undelivered", test_name, exp_q.size());
      end
      assert (beat_count == BURST * init_count) else begin
         mismatches++;
         $display("MISMATCH %s beat total: expected %0d actual %0d", test_name,
                  BURST * init_count, beat_count);
      end
      assert (dma_status == exp_status) else begin
         mismatches++;
         $display("MISMATCH %s status: expected %h actual %h", test_name,
                  exp_status, dma_status);
      end
      assert (frame_starts == vs_falls) else begin
         mismatches++;
         $display("MISMATCH %s frame_start count: expected %0d actual %0d", test_name,
                  vs_falls, frame_starts);
      end
   endtask

   task automatic vsync_pulse();
      @(negedge mipi_pclk);
      cam.valid = 1'b0;
      cam.vsync = 1'b1;
      repeat (2) @(negedge mipi_pclk);
      cam.vsync = 1'b0;
      vs_falls++;
   endtask

   task automatic pulse_trigger();
      @(negedge mipi_pclk);
      trigger = 1'b1;
      repeat (4) @(negedge mipi_pclk);
      trigger = 1'b0;
      repeat (4) @(negedge mipi_pclk);
   endtask

   // Frame of random pairs
   // Kept pairs go to the model queue
   task automatic send_frame(input bit keep, input bit gray);
      logic [47:0] px;
      logic [31:0] rnd_lo;
      logic [31:0] rnd_hi;
      int          ln;
      int          col;
      vsync_pulse();
      repeat (2) @(negedge mipi_pclk);
      for (ln = 0; ln < 4; ln++) begin
         for (col = 0; col < 8; col++) begin
            @(negedge mipi_pclk);
            rnd_lo    = $random(seed);
            rnd_hi    = $random(seed);
            px        = {rnd_hi[15:0], rnd_lo};
            cam.valid = 1'b1;
            cam.pair  = px;
            if (keep && push_left > 0) begin
               exp_q.push_back(ref_beat(px, gray));
               push_left--;
            end
         end
         @(negedge mipi_pclk);
         cam.valid = 1'b0;
         repeat (2) @(negedge mipi_pclk);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      rst_n        = 1'b0;
      cam          = '0;
      trigger      = 1'b0;
      continuous   = 1'b0;
      rgb_gray     = 1'b0;
      init_done    = 1'b0;
      wready       = 1'b1;
      rand_ready   = 1'b0;
      ready_level  = 1'b1;
      push_left    = 1 << 30;
      init_count   = 0;
      beat_count   = 0;
      vs_falls     = 0;
      frame_starts = 0;
      checks       = 0;
      mismatches   = 0;
      failures     = 0;
      test_name    = "reset";
      repeat (2) @(negedge mipi_pclk);
      rst_n = 1'b1;
      repeat (4) @(negedge mipi_pclk);

      // Only the frame after the armed vsync fall is stored
      test_name = "single_trigger";
      send_frame(0, 0);
      pulse_trigger();
      send_frame(1, 0);
      send_frame(0, 0);
      send_frame(0, 0);
      run_bursts(2);
      check_idle();
      assert (wcount == 32) else begin
         mismatches++;
         $display("MISMATCH %s wcount: expected 32 actual %0d", test_name, wcount);
      end

      test_name = "gray";
      rgb_gray  = 1'b1;
      pulse_trigger();
      send_frame(1, 1);
      vsync_pulse();
      rgb_gray = 1'b0;
      run_bursts(2);
      check_idle();

      // 96 pairs are more than the FIFO holds
      // Bursts run alongside the frames
      test_name  = "continuous";
      continuous = 1'b1;
      repeat (4) @(negedge mipi_pclk);
      fork
         repeat (3) send_frame(1, 0);
         run_bursts(6);
      join
      check_idle();

      test_name  = "random_wready";
      rand_ready = 1'b1;
      fork
         repeat (2) send_frame(1, 0);
         run_bursts(4);
      join
      rand_ready = 1'b0;
      check_idle();
      assert (!overflow) else begin
         mismatches++;
         $display("MISMATCH %s overflow: expected 0 actual 1", test_name);
      end

      // With the sink stalled only the first FIFO_DEPTH words survive
      test_name   = "overflow";
      ready_level = 1'b0;
      push_left   = `CAM_FIFO_DEPTH;
      repeat (3) send_frame(1, 0);
      assert (overflow) else begin
         mismatches++;
         $display("MISMATCH %s overflow set: expected 1 actual 0", test_name);
      end
      repeat (20) @(negedge mipi_pclk);
      ready_level = 1'b1;
      run_bursts(`CAM_FIFO_DEPTH / BURST);
      check_idle();
      assert (overflow) else begin
         mismatches++;
         $display("MISMATCH %s overflow held: expected 1 actual 0", test_name);
      end
      assert (rcount == beat_count) else begin
         mismatches++;
         $display("MISMATCH %s rcount: expected %0d actual %0d", test_name, beat_count, rcount);
      end

      $display("Summary: %0d beats compared, %0d mismatches, %0d other errors",
               checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* cam_capture_top.sv */
//////////////////////////////////////////////////
// Capture and store back end, packer to FIFO to DMA
// Input pixels are already RGB at two per clock
// wready is the only back-pressure towards the FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cam_capture_top (
   input  logic                              i_mipi_pclk,
   input  logic                              i_rst_n,
   input  cam_pixel_pkg::cam_in_t            i_cam,
   input  logic                              i_trigger_capture,
   input  logic                              i_continuous_capture,
   input  logic                              i_rgb_gray,
   input  logic                              i_dma_init_done,
   input  logic                              i_dma_wready,
   output logic                              o_dma_wvalid,
   output logic                              o_dma_wlast,
   output cam_dma_pkg::dma_beat_t            o_dma_wdata,
   output logic                              o_frame_start,
   output logic                              o_fifo_overflow,
   output logic [31:0]                       o_dma_status,
   output logic [cam_dma_pkg::DBG_CNT_W-1:0] o_dbg_wcount,
   output logic [cam_dma_pkg::DBG_CNT_W-1:0] o_dbg_rcount
);

   import cam_dma_pkg::*;

   logic        fifo_wr;
   fifo_word_t  fifo_wdata;
   logic        fifo_rd;
   fifo_word_t  fifo_rdata;
   logic        fifo_empty;
   dma_status_t dma_status;

   // Status bits sit at the bottom of the 32-bit word
   assign o_dma_status = {{(32 - $bits(dma_status_t)){1'b0}}, dma_status};

   cam_frame_packer u_packer (
      .i_mipi_pclk          (i_mipi_pclk),
      .i_rst_n              (i_rst_n),
      .i_cam                (i_cam),
      .i_trigger_capture    (i_trigger_capture),
      .i_continuous_capture (i_continuous_capture),
      .i_rgb_gray           (i_rgb_gray),
      .o_fifo_wr            (fifo_wr),
      .o_fifo_wdata         (fifo_wdata),
      .o_frame_start        (o_frame_start)
   );

   cam_dma_fifo u_fifo (
      .i_mipi_pclk (i_mipi_pclk),
      .i_rst_n     (i_rst_n),
      .i_wr        (fifo_wr),
      .i_wdata     (fifo_wdata),
      .i_rd        (fifo_rd),
      .o_rdata     (fifo_rdata),
      .o_empty     (fifo_empty),
      .o_overflow  (o_fifo_overflow)
   );

   cam_dma_writer u_writer (
      .i_mipi_pclk     (i_mipi_pclk),
      .i_rst_n         (i_rst_n),
      .i_dma_init_done (i_dma_init_done),
      .i_dma_wready    (i_dma_wready),
      .i_fifo_rdata    (fifo_rdata),
      .i_fifo_empty    (fifo_empty),
      .i_fifo_wr       (fifo_wr),
      .o_fifo_rd       (fifo_rd),
      .o_dma_wvalid    (o_dma_wvalid),
      .o_dma_wlast     (o_dma_wlast),
      .o_dma_wdata     (o_dma_wdata),
      .o_status        (dma_status),
      .o_wcount        (o_dbg_wcount),
      .o_rcount        (o_dbg_rcount)
   );

endmodule

/* cam_dma_writer.sv */
//////////////////////////////////////////////////
// DMA write side of the capture path
// Each init_done rising edge opens one burst window
// wlast falls on every CAM_DMA_BURST_LEN-th beat since reset
// wvalid follows wready in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cam_defines.svh"

module cam_dma_writer (
   input  logic                              i_mipi_pclk,
   input  logic                              i_rst_n,
   input  logic                              i_dma_init_done,
   input  logic                              i_dma_wready,
   input  cam_dma_pkg::fifo_word_t           i_fifo_rdata,
   input  logic                              i_fifo_empty,
   input  logic                              i_fifo_wr,
   output logic                              o_fifo_rd,
   output logic                              o_dma_wvalid,
   output logic                              o_dma_wlast,
   output cam_dma_pkg::dma_beat_t            o_dma_wdata,
   output cam_dma_pkg::dma_status_t          o_status,
   output logic [cam_dma_pkg::DBG_CNT_W-1:0] o_wcount,
   output logic [cam_dma_pkg::DBG_CNT_W-1:0] o_rcount
);

   import cam_dma_pkg::*;

   localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(`CAM_DMA_BURST_LEN - 1);

   logic                  init_r1;
   logic                  init_r2;
   logic                  init_r3;
   logic                  init_rise;
   logic                  dma_write;
   logic [BEAT_CNT_W-1:0] beat_cnt;
   logic                  end_of_burst;

   assign init_rise = init_r2 & ~init_r3;

   // A beat moves when the window is open, the sink is ready and data waits
   assign o_fifo_rd    = dma_write & i_dma_wready & ~i_fifo_empty;
   assign o_dma_wvalid = o_fifo_rd;

   assign end_of_burst = (beat_cnt == LAST_BEAT);
   assign o_dma_wlast  = o_dma_wvalid & end_of_burst;

   // Zero byte above each 24-bit pixel
   assign o_dma_wdata = '{pad1: 8'd0, p1: i_fifo_rdata.p1, pad0: 8'd0, p0: i_fifo_rdata.p0};

   assign o_status = '{fifo_empty: i_fifo_empty, dma_write: dma_write, dma_wready: i_dma_wready};

   //////////////////////////////////////////////////
   // Burst window and beat counter
   //////////////////////////////////////////////////

   always_ff @(posedge i_mipi_pclk) begin
      if (!i_rst_n) begin
         init_r1   <= 1'b0;
         init_r2   <= 1'b0;
         init_r3   <= 1'b0;
         dma_write <= 1'b0;
         beat_cnt  <= '0;
      end else begin
         init_r1 <= i_dma_init_done;
         init_r2 <= init_r1;
         init_r3 <= init_r2;
         // A new init edge wins over the closing beat
         if (init_rise) begin
            dma_write <= 1'b1;
         end else if (o_dma_wlast) begin
            dma_write <= 1'b0;
         end
         if (o_dma_wvalid) begin
            beat_cnt <= end_of_burst ? '0 : beat_cnt + 1'b1;
         end
      end
   end

   // Debug counters of FIFO writes and DMA beats
   always_ff @(posedge i_mipi_pclk) begin
      if (!i_rst_n) begin
         o_wcount <= '0;
         o_rcount <= '0;
      end else begin
         if (i_fifo_wr) begin
            o_wcount <= o_wcount + 1'b1;
         end
         if (o_dma_wvalid) begin
            o_rcount <= o_rcount + 1'b1;
         end
      end
   end

endmodule

/* cam_dma_fifo.sv */
//////////////////////////////////////////////////
// First word fall through FIFO for pixel pairs
// Head word is valid whenever o_empty is low
// Writes into a full FIFO are dropped, even with a read
// Overflow stays set until reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cam_defines.svh"

module cam_dma_fifo (
   input  logic                    i_mipi_pclk,
   input  logic                    i_rst_n,
   input  logic                    i_wr,
   input  cam_dma_pkg::fifo_word_t i_wdata,
   input  logic                    i_rd,
   output cam_dma_pkg::fifo_word_t o_rdata,
   output logic                    o_empty,
   output logic                    o_overflow
);

   import cam_dma_pkg::*;

   localparam int unsigned AW = $clog2(`CAM_FIFO_DEPTH);

   fifo_word_t    mem [`CAM_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          wr_en;
   logic          rd_en;

   assign full    = (count == (AW+1)'(`CAM_FIFO_DEPTH));
   assign o_empty = (count == '0);
   assign wr_en   = i_wr & ~full;
   assign rd_en   = i_rd & ~o_empty;

   // Head of the queue straight from the array
   assign o_rdata = mem[rd_ptr];

   always_ff @(posedge i_mipi_pclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_wdata;
      end
   end

   //////////////////////////////////////////////////
   // Pointers, fill level and overflow
   //////////////////////////////////////////////////

   always_ff @(posedge i_mipi_pclk) begin
      if (!i_rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         o_overflow <= 1'b0;
      end else begin
         // Pointers wrap on their own since the depth is a power of two
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (i_wr && full) begin
            o_overflow <= 1'b1;
         end
      end
   end

endmodule

/* cam_frame_packer.sv */
//////////////////////////////////////////////////
// Capture framing and pixel packing
// Controls are asynchronous levels, two flops each
// A capture starts and ends on a vsync falling edge
// A pair that comes with the arming vsync fall is not taken
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cam_defines.svh"

module cam_frame_packer (
   input  logic                    i_mipi_pclk,
   input  logic                    i_rst_n,
   input  cam_pixel_pkg::cam_in_t  i_cam,
   input  logic                    i_trigger_capture,
   input  logic                    i_continuous_capture,
   input  logic                    i_rgb_gray,
   output logic                    o_fifo_wr,
   output cam_dma_pkg::fifo_word_t o_fifo_wdata,
   output logic                    o_frame_start
);

   import cam_pixel_pkg::*;

   logic                      trig_r1;
   logic                      trig_r2;
   logic                      trig_r3;
   logic                      trig_rise;
   logic                      trig_hold;
   logic                      cont_r1;
   logic                      cont_r2;
   logic                      cont_hold;
   logic                      gray_r1;
   logic                      gray_sync;
   logic                      vs_q;
   logic                      vs_fall;
   logic                      capture;
   rgb_pixel_t [`CAM_PPC-1:0] pix_in;
   rgb_pixel_t [`CAM_PPC-1:0] pix_out;

   // Luma as 77r + 150g + 29b over 256, truncated
   function automatic rgb_pixel_t to_gray(rgb_pixel_t px);
      logic [`CAM_PIX_DEPTH+7:0] sum;
      logic [`CAM_PIX_DEPTH-1:0] y;
      sum = px.r * 8'd77 + px.g * 8'd150 + px.b * 8'd29;
      y   = sum[`CAM_PIX_DEPTH+7:8];
      return '{b: y, g: y, r: y};
   endfunction

   //////////////////////////////////////////////////
   // Control synchronizers and vsync edge
   //////////////////////////////////////////////////

   always_ff @(posedge i_mipi_pclk) begin
      if (!i_rst_n) begin
         trig_r1   <= 1'b0;
         trig_r2   <= 1'b0;
         trig_r3   <= 1'b0;
         cont_r1   <= 1'b0;
         cont_r2   <= 1'b0;
         gray_r1   <= 1'b0;
         gray_sync <= 1'b0;
         vs_q      <= 1'b0;
      end else begin
         trig_r1   <= i_trigger_capture;
         trig_r2   <= trig_r1;
         trig_r3   <= trig_r2;
         cont_r1   <= i_continuous_capture;
         cont_r2   <= cont_r1;
         gray_r1   <= i_rgb_gray;
         gray_sync <= gray_r1;
         vs_q      <= i_cam.vsync;
      end
   end

   assign trig_rise = trig_r2 & ~trig_r3;
   assign vs_fall   = vs_q & ~i_cam.vsync;

   //////////////////////////////////////////////////
   // Capture state
   //////////////////////////////////////////////////

   always_ff @(posedge i_mipi_pclk) begin
      if (!i_rst_n) begin
         trig_hold <= 1'b0;
         cont_hold <= 1'b0;
         capture   <= 1'b0;
      end else begin
         // Pending request is consumed by the first stored word
         if (trig_rise) begin
            trig_hold <= 1'b1;
         end else if (o_fifo_wr) begin
            trig_hold <= 1'b0;
         end
         // Continuous mode latches until reset
         if (cont_r2) begin
            cont_hold <= 1'b1;
         end
         // Each frame boundary re-decides whether to keep capturing
         if (vs_fall) begin
            capture <= trig_hold | cont_hold;
         end
      end
   end

   // Per pixel RGB or gray selection
   assign pix_in = i_cam.pair;

   always_comb begin
      for (int i = 0; i < `CAM_PPC; i++) begin
         pix_out[i] = gray_sync ? to_gray(pix_in[i]) : pix_in[i];
      end
   end

   // Registered write towards the FIFO
   always_ff @(posedge i_mipi_pclk) begin
      if (!i_rst_n) begin
         o_fifo_wr     <= 1'b0;
         o_frame_start <= 1'b0;
      end else begin
         o_fifo_wr     <= capture & i_cam.valid;
         o_frame_start <= vs_fall;
      end
   end

   always_ff @(posedge i_mipi_pclk) begin
      o_fifo_wdata <= pix_out;
   end

endmodule

/* cam_dma_pkg.sv */
//////////////////////////////////////////////////
// FIFO and DMA side types of the capture path
// Each pixel goes out padded to 32 bits with a zero byte
// Debug counters are 32 bits and wrap silently
//////////////////////////////////////////////////

`include "cam_defines.svh"

package cam_dma_pkg;

   // Beat index within one DMA burst
   localparam int unsigned BEAT_CNT_W = $clog2(`CAM_DMA_BURST_LEN);

   // Width of the word counters on the debug port
   localparam int unsigned DBG_CNT_W = 32;

   // One stored pixel pair
   typedef cam_pixel_pkg::pixel_pair_t fifo_word_t;

   // 64-bit beat on the DMA write port
   typedef struct packed {
      logic [7:0]                pad1;
      cam_pixel_pkg::rgb_pixel_t p1;
      logic [7:0]                pad0;
      cam_pixel_pkg::rgb_pixel_t p0;
   } dma_beat_t;

   // Live status, sits in the low bits of the status word
   typedef struct packed {
      logic fifo_empty;
      logic dma_write;
      logic dma_wready;
   } dma_status_t;

endpackage

/* cam_pixel_pkg.sv */
//////////////////////////////////////////////////
// Pixel side types of the capture path
// Channel order inside a pixel is b, g, r from the top
// A pair carries p1 in the upper half, p0 in the lower
//////////////////////////////////////////////////

`include "cam_defines.svh"

package cam_pixel_pkg;

   // One RGB pixel, blue channel in the upper bits
   typedef struct packed {
      logic [`CAM_PIX_DEPTH-1:0] b;
      logic [`CAM_PIX_DEPTH-1:0] g;
      logic [`CAM_PIX_DEPTH-1:0] r;
   } rgb_pixel_t;

   // Two pixels delivered in the same clock
   typedef struct packed {
      rgb_pixel_t p1;
      rgb_pixel_t p0;
   } pixel_pair_t;

   // Camera stream after RGB conversion
   // vsync is a level, valid qualifies the pair
   typedef struct packed {
      logic        vsync;
      logic        valid;
      pixel_pair_t pair;
   } cam_in_t;

endpackage

/* cam_defines.svh */
//////////////////////////////////////////////////
// Build constants of the capture back end
// Pixels arrive as RGB, CAM_PPC of them per clock
// The DMA beat layout assumes 8 bits per channel
// CAM_FIFO_DEPTH must be a power of two
// CAM_DMA_BURST_LEN must be at least 2
//////////////////////////////////////////////////

`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

// Bits per colour channel
`define CAM_PIX_DEPTH 8

// Pixels per clock on the camera stream
`define CAM_PPC 2

// Beats per DMA transfer
// Has to match the transfer length set up by firmware
`define CAM_DMA_BURST_LEN 16

// Entries of the DMA FIFO
// Four bursts of headroom before words get dropped
`define CAM_FIFO_DEPTH 64

`endif
